/* icache_params.svh */
// cache geometry macros, included by the package and by any module that sizes storage.
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// organisation.
`define ICACHE_WAYS 2 // ways per set.
`define ICACHE_LINES 16 // sets, i.e. lines per way.
`define ICACHE_LINE_WORDS 4 // words per line.

// widths.
`define ICACHE_ADDR_W 32 // byte address.
`define ICACHE_WORD_W 32 // instruction word.
`define ICACHE_LINE_ADDR_W 4 // log2 of ICACHE_LINES.
`define ICACHE_WORD_SEL_W 2 // log2 of ICACHE_LINE_WORDS.

// whatever is left above index, word select and the two byte bits.
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_LINE_ADDR_W - `ICACHE_WORD_SEL_W - 2)

`endif

/* icache_pkg.sv */
// shared types for the instruction cache, imported by every design unit.
`include "icache_params.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0] addr_t; // fetch byte address.
    typedef logic [`ICACHE_WORD_W-1:0] word_t; // one instruction.
    typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_W-1:0] line_t; // word w at bits w*32.
    typedef logic [`ICACHE_TAG_W-1:0] tag_t; // upper address bits.
    typedef logic [`ICACHE_LINE_ADDR_W-1:0] line_addr_t; // set index.
    typedef logic [`ICACHE_WORD_SEL_W-1:0] word_sel_t; // word within line.
    typedef logic [`ICACHE_WAYS-1:0] way_t; // one-hot.

    // valid bit sits on top of the tag.
    typedef logic [`ICACHE_TAG_W:0] tag_entry_t;

    // controller states.
    typedef enum logic [1:0] {
        st_sweep, // clearing valid bits after reset.
        st_run, // normal lookup.
        st_req, // mem_req high, waiting for ack.
        st_wait_release // waiting for ack to drop.
    } ctrl_state_t;

endpackage

/* icache_ifs.sv */
// lookup interfaces between the cache controller and the tag and data banks.

interface tag_lookup_if
    import icache_pkg::*;
();

    line_addr_t stage1_line_addr; // read index.
    line_addr_t stage2_line_addr; // write index, sweep or fill.
    tag_t stage2_tag; // tag to compare and to write.
    way_t update_way; // fill victim.
    logic update; // write valid entry.
    logic clear; // write invalid entry to all ways.
    logic stage1_adv; // fetch accepted this cycle.
    logic tag_hit;
    way_t tag_hit_way;

    modport ctrl (
        output stage1_line_addr, stage2_line_addr, stage2_tag,
        output update_way, update, clear, stage1_adv,
        input tag_hit
    );

    modport bank (
        input stage1_line_addr, stage2_line_addr, stage2_tag,
        input update_way, update, clear, stage1_adv,
        output tag_hit, tag_hit_way
    );

endinterface

interface data_lookup_if
    import icache_pkg::*;
();

    line_addr_t stage1_line_addr;
    logic stage1_adv;
    word_sel_t stage2_word_sel; // word picked in stage 2.
    line_addr_t update_line_addr; // fill index.
    way_t update_way;
    logic update;
    line_t fill_line; // line from memory.
    word_t hit_word;

    modport ctrl (
        output stage1_line_addr, stage1_adv, stage2_word_sel,
        output update_line_addr, update_way, update, fill_line,
        input hit_word
    );

    modport bank (
        input stage1_line_addr, stage1_adv, stage2_word_sel,
        input update_line_addr, update_way, update, fill_line,
        output hit_word
    );

endinterface

/* sdp_ram.sv */
// simple dual-port RAM, port a writes by column and port b reads into a register.
`include "icache_params.svh"

module sdp_ram
    import icache_pkg::*;
#(
    parameter int num_col = 2, // one column per way.
    parameter int col_width = 25
) (
    input logic clk,
    input logic a_en,
    input logic [num_col-1:0] a_wbe,
    input line_addr_t a_addr,
    input logic [num_col*col_width-1:0] a_wdata,
    input logic b_en,
    input line_addr_t b_addr,
    output logic [num_col*col_width-1:0] b_rdata
);

    logic [num_col*col_width-1:0] mem [`ICACHE_LINES]; // one row per set.

    // write side.
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_col; i++) begin
            if (a_en && a_wbe[i]) begin
                mem[a_addr][i*col_width +: col_width] <= a_wdata[i*col_width +: col_width];
            end
        end
    end

    // read side, held while b_en is low so stage 2 keeps its data.
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

endmodule

/* itag_banks.sv */
// valid and tag storage for all ways plus the stage-2 hit compare.
`include "icache_params.svh"

module itag_banks
    import icache_pkg::*;
(
    input logic clk,
    input logic rst,
    tag_lookup_if.bank lookup
);

    tag_entry_t [`ICACHE_WAYS-1:0] tag_line; // stage-2 entries, one per way.
    logic hit_allowed; // stage 2 holds a freshly read fetch.
    logic wr_en;
    way_t wr_way;

    // stalled or empty stage 2 never hits.
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_allowed <= 1'b0;
        end else begin
            hit_allowed <= lookup.stage1_adv;
        end
    end

    assign wr_en = lookup.update | lookup.clear;
    assign wr_way = lookup.clear ? '1 : lookup.update_way; // sweep clears every way.

    sdp_ram #(
        .num_col(`ICACHE_WAYS),
        .col_width(`ICACHE_TAG_W + 1)
    ) i_tag_ram (
        .clk(clk),
        .a_en(wr_en),
        .a_wbe(wr_way),
        .a_addr(lookup.stage2_line_addr),
        .a_wdata({`ICACHE_WAYS{~lookup.clear, lookup.stage2_tag}}), // valid is 0 on clear.
        .b_en(lookup.stage1_adv),
        .b_addr(lookup.stage1_line_addr),
        .b_rdata(tag_line)
    );

    // per-way compare, valid bit included.
    always_comb begin
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            lookup.tag_hit_way[i] = hit_allowed && (tag_line[i] == {1'b1, lookup.stage2_tag});
        end
    end

    assign lookup.tag_hit = |lookup.tag_hit_way;

endmodule

/* icache_data_banks.sv */
// line storage for all ways, picks the hitting way and word in stage 2.
`include "icache_params.svh"

module icache_data_banks
    import icache_pkg::*;
(
    input logic clk,
    input way_t tag_hit_way, // one-hot, from the tag bank.
    data_lookup_if.bank lookup
);

    line_t [`ICACHE_WAYS-1:0] data_line; // stage-2 lines, one per way.
    line_t hit_line;

    sdp_ram #(
        .num_col(`ICACHE_WAYS),
        .col_width(`ICACHE_LINE_WORDS * `ICACHE_WORD_W)
    ) i_data_ram (
        .clk(clk),
        .a_en(lookup.update),
        .a_wbe(lookup.update_way), // only the victim way.
        .a_addr(lookup.update_line_addr),
        .a_wdata({`ICACHE_WAYS{lookup.fill_line}}),
        .b_en(lookup.stage1_adv),
        .b_addr(lookup.stage1_line_addr),
        .b_rdata(data_line)
    );

    // and-or mux, hit way is one-hot or zero.
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (tag_hit_way[i]) begin
                hit_line = hit_line | data_line[i];
            end
        end
    end

    // then the requested word.
    assign lookup.hit_word = hit_line[lookup.stage2_word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

/* icache_ctrl.sv */
// cache controller: pipeline advance, reset sweep, miss fill and memory handshake.
`include "icache_params.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic fetch_valid,
    input addr_t fetch_addr,
    output logic fetch_ready,
    output logic resp_valid,
    output word_t resp_word,
    output logic mem_req,
    output line_addr_t mem_line_addr,
    input logic mem_ack,
    input line_t mem_line,
    tag_lookup_if.ctrl tag_lookup,
    data_lookup_if.ctrl data_lookup
);

    ctrl_state_t state, state_nxt;
    addr_t s2_addr; // stage-2 fetch address.
    logic s2_valid;
    logic s2_miss; // stage 2 holds a fetch that missed.
    logic stage1_adv;
    logic fill; // line arrives this cycle.
    line_addr_t s1_line_addr;
    line_addr_t s2_line_addr;
    word_sel_t s2_word_sel;
    tag_t s2_tag;
    line_addr_t sweep_cnt;
    way_t rr_way; // round-robin victim.
    word_t fill_word;

    // address fields: tag | index | word | byte.
    assign s1_line_addr = fetch_addr[2+`ICACHE_WORD_SEL_W +: `ICACHE_LINE_ADDR_W];
    assign s2_line_addr = s2_addr[2+`ICACHE_WORD_SEL_W +: `ICACHE_LINE_ADDR_W];
    assign s2_word_sel = s2_addr[2 +: `ICACHE_WORD_SEL_W];
    assign s2_tag = s2_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

    assign s2_miss = s2_valid && !tag_lookup.tag_hit;
    assign fill = (state == st_req) && mem_ack; // first ack edge.
    assign fetch_ready = (state == st_run) && !s2_miss; // stall behind a miss.
    assign stage1_adv = fetch_valid && fetch_ready;

    // state machine.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_sweep;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_sweep: if (sweep_cnt == line_addr_t'(`ICACHE_LINES - 1)) state_nxt = st_run;
            st_run: if (s2_miss) state_nxt = st_req;
            st_req: if (mem_ack) state_nxt = st_wait_release;
            st_wait_release: if (!mem_ack) state_nxt = st_run; // four-phase end.
            default: state_nxt = st_sweep;
        endcase
    end

    // one set per cycle during the sweep.
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
        end else if (state == st_sweep) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    // stage 2 valid, held on a miss until the fill.
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (fill) begin
            s2_valid <= 1'b0;
        end else if (!s2_miss) begin
            s2_valid <= stage1_adv;
        end
    end

    always_ff @(posedge clk) begin
        if (stage1_adv) begin
            s2_addr <= fetch_addr;
        end
    end

    // victim pointer, rotates per fill.
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_way <= way_t'(1);
        end else if (fill) begin
            rr_way <= {rr_way[`ICACHE_WAYS-2:0], rr_way[`ICACHE_WAYS-1]};
        end
    end

    // response, either a hit or the word out of the fill line.
    assign fill_word = mem_line[s2_word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= (s2_valid && tag_lookup.tag_hit) || fill;
        end
    end

    always_ff @(posedge clk) begin
        resp_word <= fill ? fill_word : data_lookup.hit_word;
    end

    // memory side.
    assign mem_req = (state == st_req); // held until ack.
    assign mem_line_addr = s2_line_addr;

    // tag bank.
    assign tag_lookup.stage1_line_addr = s1_line_addr;
    assign tag_lookup.stage2_line_addr = (state == st_sweep) ? sweep_cnt : s2_line_addr;
    assign tag_lookup.stage2_tag = s2_tag;
    assign tag_lookup.update_way = rr_way;
    assign tag_lookup.update = fill;
    assign tag_lookup.clear = (state == st_sweep);
    assign tag_lookup.stage1_adv = stage1_adv;

    // data bank.
    assign data_lookup.stage1_line_addr = s1_line_addr;
    assign data_lookup.stage1_adv = stage1_adv;
    assign data_lookup.stage2_word_sel = s2_word_sel;
    assign data_lookup.update_line_addr = s2_line_addr;
    assign data_lookup.update_way = rr_way;
    assign data_lookup.update = fill;
    assign data_lookup.fill_line = mem_line;

endmodule

/* icache_top.sv */
// instruction cache top level, plain fetch and memory ports around controller and banks.

module icache_top
    import icache_pkg::*;
(
    input logic clk,
    input logic rst,

    // fetch side.
    input logic fetch_valid,
    input addr_t fetch_addr,
    output logic fetch_ready,
    output logic resp_valid,
    output word_t resp_word,

    // memory side, four-phase.
    output logic mem_req,
    output line_addr_t mem_line_addr,
    input logic mem_ack,
    input line_t mem_line
);

    tag_lookup_if tag_if ();
    data_lookup_if data_if ();

    icache_ctrl i_icache_ctrl (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready),
        .resp_valid(resp_valid),
        .resp_word(resp_word),
        .mem_req(mem_req),
        .mem_line_addr(mem_line_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line),
        .tag_lookup(tag_if.ctrl),
        .data_lookup(data_if.ctrl)
    );

    itag_banks i_itag_banks (
        .clk(clk),
        .rst(rst),
        .lookup(tag_if.bank)
    );

    // hit way crosses from tag bank to data bank.
    icache_data_banks i_icache_data_banks (
        .clk(clk),
        .tag_hit_way(tag_if.tag_hit_way),
        .lookup(data_if.bank)
    );

endmodule

/* tb_icache_mem.sv */
// behavioral line memory for the cache testbench, answers the four-phase handshake.
`include "icache_params.svh"

module tb_icache_mem
    import icache_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic mem_req,
    input line_addr_t mem_line_addr,
    output logic mem_ack,
    output line_t mem_line
);

    timeunit 1ns;
    timeprecision 100ps;

    int wait_cycles; // cycles left before ack.
    bit busy; // request seen, ack pending.

    // word w of set l holds its byte address xor a marker.
    function automatic line_t build_line(line_addr_t l);
        line_t line;
        for (int w = 0; w < `ICACHE_LINE_WORDS; w++) begin
            line[w*32 +: 32] = {24'h0, l, 2'(w), 2'b00} ^ 32'h5a5a_0000;
        end
        return line;
    endfunction

    // acts 10 ns after each rising edge, like the fetch driver.
    initial begin
        mem_ack = 1'b0;
        mem_line = '0;
        busy = 1'b0;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            #10;
            if (rst) begin
                mem_ack = 1'b0;
                busy = 1'b0;
            end else if (mem_ack) begin
                if (!mem_req) begin
                    mem_ack = 1'b0; // req dropped, release.
                end
            end else if (mem_req) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_cycles = int'($urandom % 4); // ack after 1 to 4 cycles.
                end else if (wait_cycles == 0) begin
                    mem_line = build_line(mem_line_addr);
                    mem_ack = 1'b1;
                    busy = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

endmodule

/* tb_icache.sv */
// testbench top that runs directed cache tests against a reference model.
`include "icache_params.svh"

module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_fetches = 218; // all fetches issued by the tests.
    localparam int timeout_cycles = 64 * num_fetches + `ICACHE_LINES + 5;

    logic clk;
    logic rst;
    logic fetch_valid;
    addr_t fetch_addr;
    logic fetch_ready;
    logic resp_valid;
    word_t resp_word;
    logic mem_req;
    line_addr_t mem_line_addr;
    logic mem_ack;
    line_t mem_line;

    int cycles = 0;
    int req_rises = 0; // mem_req rising edges seen.
    int rises_at_resp = 0; // req_rises at the last response.
    logic req_prev = 1'b0;

    // reference model tag store per way and set.
    tag_t model_tag [`ICACHE_WAYS][`ICACHE_LINES];
    bit model_valid [`ICACHE_WAYS][`ICACHE_LINES];
    int model_rr = 0; // next victim way.
    int model_misses = 0;

    // fetches accepted but not yet answered.
    addr_t pend_addr[$];
    bit pend_hit[$];
    int pend_cycle[$];

    icache_top i_icache_top (
        .clk(clk),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready),
        .resp_valid(resp_valid),
        .resp_word(resp_word),
        .mem_req(mem_req),
        .mem_line_addr(mem_line_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line)
    );

    tb_icache_mem i_mem (
        .clk(clk),
        .rst(rst),
        .mem_req(mem_req),
        .mem_line_addr(mem_line_addr),
        .mem_ack(mem_ack),
        .mem_line(mem_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_line_addr(string name, line_addr_t got, line_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic line_addr_t set_of(addr_t a);
        return a[7:4]; // above word select and byte bits.
    endfunction

    // memory word is the byte address of set and word xor a marker.
    function automatic word_t expected_word(addr_t a);
        return {24'h0, a[7:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    // true on hit; a miss fills the round-robin way.
    function automatic bit model_lookup(addr_t a);
        line_addr_t set_idx;
        tag_t tag;
        set_idx = set_of(a);
        tag = a[31:8];
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (model_valid[i][set_idx] && model_tag[i][set_idx] == tag) begin
                return 1'b1;
            end
        end
        model_valid[model_rr][set_idx] = 1'b1;
        model_tag[model_rr][set_idx] = tag;
        model_rr = (model_rr + 1) % `ICACHE_WAYS;
        model_misses++;
        return 1'b0;
    endfunction

    // oldest pending fetch answers each response.
    task automatic check_response;
        addr_t a;
        bit hit;
        int acc;
        if (pend_addr.size() == 0) begin
            abort_run("response arrived with no fetch outstanding");
        end else begin
            a = pend_addr.pop_front();
            hit = pend_hit.pop_front();
            acc = pend_cycle.pop_front();
            check_word("resp_word", resp_word, expected_word(a));
            check_flag("miss", req_rises != rises_at_resp, !hit);
            if (hit) begin
                check_flag("resp_on_time", cycles == acc + 2, 1'b1); // one cycle after accept.
            end
            rises_at_resp = req_rises;
        end
    endtask

    // outputs sampled at the falling edge away from input changes.
    always @(negedge clk) begin
        if (rst) begin
            req_prev = 1'b0;
        end else begin
            if (mem_req && !req_prev) begin
                req_rises++;
                if (pend_addr.size() == 0) begin
                    abort_run("memory request with no fetch outstanding");
                end else begin
                    check_line_addr("mem_line_addr", mem_line_addr, set_of(pend_addr[0]));
                end
            end
            req_prev = mem_req;
            if (resp_valid) begin
                check_response();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            abort_run("timeout: the cache stopped answering fetches");
        end
    end

    // called and returns 10 ns after a rising edge.
    task automatic issue_fetch(addr_t a);
        bit accepted;
        accepted = 1'b0;
        fetch_valid = 1'b1;
        fetch_addr = a;
        while (!accepted) begin
            @(negedge clk);
            if (fetch_ready) begin
                accepted = 1'b1;
                pend_addr.push_back(a);
                pend_hit.push_back(model_lookup(a));
                pend_cycle.push_back(cycles);
            end
            @(posedge clk);
            #10;
        end
    endtask

    task automatic idle_cycles(int n);
        fetch_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drain;
        fetch_valid = 1'b0;
        while (pend_addr.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic test_reset_sweep;
        int low_cycles;
        low_cycles = 0;
        @(negedge clk);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("mem_req", mem_req, 1'b0);
        while (!fetch_ready) begin
            low_cycles++;
            @(negedge clk);
        end
        check_count("sweep cycles", low_cycles, `ICACHE_LINES);
        @(posedge clk);
        #10;
        issue_fetch(32'h0000_1230); // cold miss in set 3.
        drain();
        check_count("requests after first fetch", req_rises, 1);
    endtask

    task automatic test_hits_after_fill;
        int base;
        base = req_rises;
        issue_fetch(32'h0000_1234);
        issue_fetch(32'h0000_1238);
        issue_fetch(32'h0000_123c);
        drain();
        check_count("requests on resident line", req_rises, base);
    endtask

    task automatic test_streaming;
        int base;
        int start;
        issue_fetch(32'h0000_1240); // bring set 4 in.
        drain();
        base = req_rises;
        start = cycles;
        for (int i = 0; i < 8; i++) begin
            issue_fetch(addr_t'(32'h0000_1230 + 4 * i)); // valid held every cycle.
        end
        check_count("streaming accept cycles", cycles - start, 8); // one fetch per cycle.
        drain();
        check_count("requests while streaming", req_rises, base);
    endtask

    // three tags in set 9 with two ways.
    task automatic test_replacement;
        int base;
        base = req_rises;
        issue_fetch(32'h0001_0090); // a to way 0.
        issue_fetch(32'h0002_0094); // b to way 1.
        issue_fetch(32'h0003_0098); // c evicts a.
        issue_fetch(32'h0001_009c); // a evicts b.
        issue_fetch(32'h0003_0090); // c still hits.
        drain();
        check_count("replacement requests", req_rises - base, 4);
    endtask

    task automatic test_random_stream;
        int base_rises;
        int base_misses;
        int idx;
        base_rises = req_rises;
        base_misses = model_misses;
        for (int n = 0; n < 200; n++) begin
            idle_cycles(int'($urandom % 3));
            idx = int'($urandom % 48);
            // tags 5..7, sets 0..3, words 0..3.
            issue_fetch(addr_t'((idx / 16 + 5) * 256 + ((idx / 4) % 4) * 16 + (idx % 4) * 4));
        end
        drain();
        check_count("random miss count", req_rises - base_rises, model_misses - base_misses);
    endtask

    initial begin
        void'($urandom(32'hafbd_36a9));
        rst = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        test_reset_sweep();
        test_hits_after_fill();
        test_streaming();
        test_replacement();
        test_random_stream();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* files.f */
+incdir+.
icache_pkg.sv
icache_ifs.sv
sdp_ram.sv
itag_banks.sv
icache_data_banks.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it; exit status is the result.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    -f files.f --top-module tb_icache -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_icache
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
